/* bench/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
  output logic clk
);

  localparam real HalfNs = 2.0;  // 4 ns period

  initial begin
    clk = 1'b0;
  end

  always #(HalfNs) clk = ~clk;

endmodule

/* bench/memModel.sv */
`timescale 1ns/1ps

module memModel (
  input  logic           clk,
  input  logic           rst,
  input  logic           memReq,
  input  logic           memWrite,
  input  logic [31:0]    memAddr,
  input  cachePkg::wordT wdata,
  output logic           dataOk,
  output cachePkg::wordT memRdata
);

  localparam int          MemWords = 16384;  // 64 KB window
  localparam logic [15:0] Seed     = 16'd4427;

  cachePkg::wordT mem [MemWords];

  logic [15:0] lfsr;
  logic        active;
  logic        isWrite;
  int          base;
  int          beat;
  int          gap;

  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // window keeps tag bits 17:14, set bits 11:6 and the word offset
  function automatic int winIdx(input logic [31:0] a);
    return int'({a[17:14], a[11:6], a[5:2]});
  endfunction

  task automatic pickGap();
    gap = 0;
    repeat (2) begin
      lfsr = lfsrStep(lfsr);
      gap  = gap * 2 + int'(lfsr[0]);
    end
  endtask

  initial begin
    for (int i = 0; i < MemWords; i++) begin
      mem[i] = (32'(i) * 32'h9E3779B1) ^ {2'b10, 16'(i), 14'(~i)};
    end
    dataOk   = 1'b0;
    memRdata = '0;
  end

  //////////////////////////////////////////////////
  // burst engine, one word per dataOk strobe
  //////////////////////////////////////////////////
  always @(posedge clk or posedge rst) begin
    if (rst) begin
      dataOk <= 1'b0;
      active = 1'b0;
      beat   = 0;
      gap    = 0;
      lfsr   = Seed;
    end else begin
      dataOk <= 1'b0;
      if (dataOk) begin  // word taken by the cache at this edge
        if (isWrite) mem[base + beat] = wdata;
        beat++;
      end
      if (!active) begin
        if (memReq) begin
          active  = 1'b1;
          isWrite = memWrite;
          base    = winIdx(memAddr);
          beat    = 0;
          pickGap();
        end
      end else if (beat == cachePkg::LineWords) begin
        active = 1'b0;  // wait a cycle for the next burst
      end else if (gap > 0) begin
        gap--;
      end else begin
        dataOk   <= 1'b1;
        memRdata <= mem[base + beat];
        pickGap();
      end
    end
  end

endmodule

/* bench/setCacheTb.sv */
`timescale 1ns/1ps

module setCacheTb;

  localparam int          TestCount   = 225;  // cpu accesses over all tests
  localparam int          MemWords    = 16384;
  localparam logic [15:0] Seed        = 16'd4427;
  localparam int          ClkNs       = 4;
  localparam int          BurstCycles = 4 * cachePkg::LineWords;
  localparam int          WatchdogNs  = TestCount * 2 * BurstCycles * ClkNs;

  logic             clk;
  logic             rst;
  logic             req;
  cachePkg::cpuReqT cpuReq;
  cachePkg::wordT   rdata;
  logic             ok;
  logic             stall;
  logic             miss;
  logic             memReq;
  logic             memWrite;
  logic [31:0]      memAddr;
  cachePkg::wordT   wdata;
  logic             dataOk;
  cachePkg::wordT   memRdata;

  cachePkg::wordT shadow [MemWords];
  cachePkg::wordT wbWords [$];
  logic [15:0]    lfsr;
  logic [31:0]    wbAddr;
  logic           sawReq;
  logic           sawWrite;
  logic           sawStall;
  logic           sawMiss;
  logic           pendRead;
  cachePkg::wordT pendExp;
  int             errors;
  int             passCount;
  int             failCount;
  int             lastCycles;
  int             rdCount;
  int             wbCount;

  clockGen i_clockGen (.clk(clk));

  setCache i_setCache (
    .clk      (clk),
    .addr_ok  (rst),
    .req      (req),
    .cpuReq   (cpuReq),
    .rdata    (rdata),
    .ok       (ok),
    .stall    (stall),
    .miss     (miss),
    .memReq   (memReq),
    .memWrite (memWrite),
    .memAddr  (memAddr),
    .wdata    (wdata),
    .dataOk   (dataOk),
    .memRdata (memRdata)
  );

  memModel i_memModel (
    .clk      (clk),
    .rst      (rst),
    .memReq   (memReq),
    .memWrite (memWrite),
    .memAddr  (memAddr),
    .wdata    (wdata),
    .dataOk   (dataOk),
    .memRdata (memRdata)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic int winIdx(input logic [31:0] a);
    return int'({a[17:14], a[11:6], a[5:2]});
  endfunction

  function automatic logic [31:0] mkAddr(input int tag, input int set, input int word);
    return {18'(tag), 8'(set), 4'(word), 2'b00};
  endfunction

  // expected read word, all earlier writes merged
  function automatic cachePkg::wordT refRead(input logic [31:0] a);
    return shadow[winIdx(a)];
  endfunction

  task automatic takeBits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrStep(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic mergeShadow(input logic [31:0] a, input cachePkg::wordT d,
                             input cachePkg::byteEnT be);
    int idx;
    idx = winIdx(a);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) shadow[idx][b*8 +: 8] = d[b*8 +: 8];
    end
  endtask

  task automatic access(input logic [31:0] a, input logic wr, input cachePkg::wordT d,
                        input cachePkg::byteEnT be);
    @(posedge clk);
    sawReq   = 1'b0;
    sawWrite = 1'b0;
    sawStall = 1'b0;
    sawMiss  = 1'b0;
    rdCount  = 0;
    wbCount  = 0;
    wbWords.delete();
    pendRead = !wr;
    pendExp  = refRead(a);
    req    <= 1'b1;
    cpuReq <= '{addr: a, wdata: d, byteEn: be, write: wr};
    lastCycles = 0;
    do begin
      @(posedge clk);
      req <= 1'b0;
      lastCycles++;
      if (memReq) sawReq = 1'b1;
      if (memReq && memWrite) sawWrite = 1'b1;
      if (stall) sawStall = 1'b1;
      if (miss) sawMiss = 1'b1;
      assert (!memReq || stall) else begin
        $display("ERROR %0t: memReq high while stall is low", $time);
        errors++;
      end
    end while (!ok);
    if (wr) mergeShadow(a, d, be);
  endtask

  task automatic report(input string name, input int errBefore);
    if (errors == errBefore) begin
      passCount++;
      $display("test %s: pass", name);
    end else begin
      failCount++;
      $display("test %s: FAIL (%0d errors)", name, errors - errBefore);
    end
  endtask

  //////////////////////////////////////////////////
  // compare and bus monitor
  //////////////////////////////////////////////////
  always @(posedge clk) begin
    if (!rst && ok && pendRead) begin
      assert (rdata == pendExp) else begin
        $display("ERROR %0t: read data %h, expected %h", $time, rdata, pendExp);
        errors++;
      end
    end
  end

  always @(posedge clk) begin
    if (memReq && dataOk) begin
      if (memWrite) begin
        wbCount++;
        wbAddr = memAddr;
        wbWords.push_back(wdata);
      end else begin
        rdCount++;
      end
    end
  end

  initial begin
    #(WatchdogNs);
    $display("watchdog expired, the cache stopped answering before the tests ended");
    $display("Test failures found");
    $finish;
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  initial begin
    int               errBefore;
    int               idx;
    logic [31:0]      v;
    logic [31:0]      a;
    logic [31:0]      r;
    cachePkg::byteEnT be;
    rst       = 1'b1;
    req       = 1'b0;
    cpuReq    = '0;
    pendRead  = 1'b0;
    pendExp   = '0;
    errors    = 0;
    passCount = 0;
    failCount = 0;
    lfsr      = Seed;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    foreach (shadow[i]) shadow[i] = i_memModel.mem[i];  // memory image at start

    // test 1, cold read miss
    errBefore = errors;
    access(mkAddr(1, 1, 3), 1'b0, '0, '0);
    assert (sawReq && !sawWrite) else begin
      $display("ERROR %0t: memReq=%0b memWrite seen=%0b", $time, sawReq, sawWrite);
      errors++;
    end
    assert (rdCount == 16 && wbCount == 0) else begin
      $display("ERROR %0t: %0d fill strobes, %0d write strobes", $time, rdCount, wbCount);
      errors++;
    end
    assert (sawStall && sawMiss) else begin
      $display("ERROR %0t: cold miss showed miss=%0b stall=%0b", $time, sawMiss, sawStall);
      errors++;
    end
    report("1 cold read miss", errBefore);

    // test 2, read hit on the same line
    errBefore = errors;
    access(mkAddr(1, 1, 9), 1'b0, '0, '0);
    assert (lastCycles == 2 && !sawReq && !sawStall && !sawMiss) else begin
      $display("ERROR %0t: hit took %0d cycles, memReq=%0b miss=%0b stall=%0b",
               $time, lastCycles, sawReq, sawMiss, sawStall);
      errors++;
    end
    report("2 read hit", errBefore);

    // test 3, partial write hit then read back
    errBefore = errors;
    access(mkAddr(1, 1, 5), 1'b1, 32'hA1B2C3D4, 4'b0101);
    assert (lastCycles == 2 && !sawReq && !sawStall && !sawMiss) else begin
      $display("ERROR %0t: write hit took %0d cycles, miss=%0b stall=%0b",
               $time, lastCycles, sawMiss, sawStall);
      errors++;
    end
    access(mkAddr(1, 1, 5), 1'b0, '0, '0);
    report("3 partial write hit", errBefore);

    // test 4, five tags in set 40 evict the first one
    errBefore = errors;
    for (int t = 0; t < 5; t++) begin
      takeBits(32, v);
      access(mkAddr(t, 40, (t * 3) % 16), 1'b1, v, 4'hF);
    end
    assert (wbCount == 16 && wbAddr == mkAddr(0, 40, 0)) else begin
      $display("ERROR %0t: %0d write-back words at %h", $time, wbCount, wbAddr);
      errors++;
    end
    assert (sawStall && sawMiss) else begin
      $display("ERROR %0t: eviction showed miss=%0b stall=%0b", $time, sawMiss, sawStall);
      errors++;
    end
    for (int i = 0; i < wbWords.size(); i++) begin
      idx = winIdx(mkAddr(0, 40, i));
      assert (wbWords[i] == shadow[idx]) else begin
        $display("ERROR %0t: write-back word %0d is %h, expected %h",
                 $time, i, wbWords[i], shadow[idx]);
        errors++;
      end
    end
    report("4 dirty eviction", errBefore);

    // test 5, random mix over sets 8 to 11
    errBefore = errors;
    for (int n = 0; n < 200; n++) begin
      takeBits(1, r);
      takeBits(3, v);
      a = {18'(v), 8'd8, 6'd0};
      takeBits(2, v);
      a[7:6] = v[1:0];
      takeBits(4, v);
      a[5:2] = v[3:0];
      takeBits(4, v);
      be = v[3:0];
      takeBits(32, v);
      access(a, r[0], v, be);
    end
    // four fresh tags per set push every mixed line out
    for (int s = 8; s < 12; s++) begin
      for (int t = 8; t < 12; t++) begin
        access(mkAddr(t, s, 0), 1'b0, '0, '0);
      end
    end
    for (int s = 8; s < 12; s++) begin
      for (int t = 0; t < 8; t++) begin
        for (int w = 0; w < cachePkg::LineWords; w++) begin
          idx = winIdx(mkAddr(t, s, w));
          assert (i_memModel.mem[idx] == shadow[idx]) else begin
            $display("ERROR %0t: memory word %0d is %h, expected %h",
                     $time, idx, i_memModel.mem[idx], shadow[idx]);
            errors++;
          end
        end
      end
    end
    report("5 random mix", errBefore);

    $display("tests: %0d passed, %0d failed, %0d errors", passCount, failCount, errors);
    if (failCount == 0 && errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* rtl/cacheCtrl.sv */
`timescale 1ns/1ps

module cacheCtrl (
  input  logic              clk,
  input  logic              addr_ok,
  // cpu side
  input  logic              req,
  input  cachePkg::cpuReqT  cpuReq,
  output cachePkg::wordT    rdata,
  output logic              ok,
  output logic              stall,
  output logic              miss,
  // lookup results
  input  logic              hit,
  input  cachePkg::wayMaskT hitWays,
  input  cachePkg::wayIdxT  selWay,
  input  cachePkg::wayReadT selRead,
  // way writes
  output cachePkg::wayMaskT lineWe,
  output cachePkg::byteEnT  byteEn,
  output cachePkg::wordIdxT wordIdx,
  output cachePkg::wordT    wrWord,
  output cachePkg::wayMaskT tagWe,
  output cachePkg::wayMaskT setValid,
  output cachePkg::wayMaskT setDirty,
  output cachePkg::wayMaskT clrDirty,
  output logic              touch,
  // memory bus
  output logic              memReq,
  output logic              memWrite,
  output logic [31:0]       memAddr,
  output cachePkg::wordT    wdata,
  input  logic              dataOk,
  input  cachePkg::wordT    memRdata
);

  cachePkg::ctrlStateT state;
  cachePkg::ctrlStateT nextState;
  cachePkg::wordIdxT   count;      // burst word counter
  cachePkg::wordIdxT   reqWord;
  cachePkg::wayMaskT   selMask;
  cachePkg::wordT      hitWord;
  logic                lastBeat;
  logic                burstEntry;

  assign reqWord  = cpuReq.addr[cachePkg::WordBits+1:2];
  assign selMask  = cachePkg::wayMaskT'(1) << selWay;
  assign hitWord  = selRead.line[{reqWord, 5'd0} +: 32];
  assign lastBeat = dataOk && (count == cachePkg::wordIdxT'(cachePkg::LineWords - 1));

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////
  always_comb begin
    nextState = state;
    case (state)
      cachePkg::Idle: begin
        if (req) nextState = cachePkg::Lookup;
      end
      cachePkg::Lookup: begin
        if (!hit) begin
          // victim dirty -> write it back before the fill
          nextState = (selRead.valid && selRead.dirty) ? cachePkg::WriteBack
                                                       : cachePkg::Refill;
        end else if (!req) begin
          nextState = cachePkg::Idle;
        end
      end
      cachePkg::WriteBack: begin
        if (lastBeat) nextState = cachePkg::Refill;
      end
      cachePkg::Refill: begin
        if (lastBeat) nextState = cachePkg::Finish;
      end
      cachePkg::Finish: begin
        nextState = req ? cachePkg::Lookup : cachePkg::Idle;
      end
      default: nextState = cachePkg::Idle;
    endcase
  end

  always_ff @(posedge clk or posedge addr_ok) begin
    if (addr_ok) begin
      state <= cachePkg::Idle;
    end else begin
      state <= nextState;
    end
  end

  assign burstEntry = (nextState != state) &&
                      (nextState inside {cachePkg::WriteBack, cachePkg::Refill});

  always_ff @(posedge clk or posedge addr_ok) begin
    if (addr_ok) begin
      count <= '0;
    end else if (burstEntry) begin
      count <= '0;
    end else if (dataOk && memReq) begin
      count <= count + 1'b1;  // one word per strobe
    end
  end

  //////////////////////////////////////////////////
  // way writes and cpu reply
  //////////////////////////////////////////////////
  always_comb begin
    lineWe   = '0;
    tagWe    = '0;
    setValid = '0;
    setDirty = '0;
    clrDirty = '0;
    byteEn   = cpuReq.byteEn;
    wordIdx  = reqWord;
    wrWord   = cpuReq.wdata;
    touch    = 1'b0;
    ok       = 1'b0;
    rdata    = cpuReq.write ? cpuReq.wdata : hitWord;
    case (state)
      cachePkg::Lookup: begin
        if (hit) begin
          ok    = 1'b1;
          touch = 1'b1;
          if (cpuReq.write) begin
            lineWe   = hitWays;
            setDirty = hitWays;
          end
        end
      end
      cachePkg::Refill: begin
        byteEn  = '1;
        wordIdx = count;
        wrWord  = memRdata;
        if (dataOk) lineWe = selMask;
      end
      cachePkg::Finish: begin
        ok       = 1'b1;
        touch    = 1'b1;
        tagWe    = selMask;
        setValid = selMask;
        if (cpuReq.write) begin
          lineWe   = selMask;  // merge the pending write into the new line
          setDirty = selMask;
        end else begin
          clrDirty = selMask;
        end
      end
      default: ;
    endcase
  end

  assign stall    = state inside {cachePkg::WriteBack, cachePkg::Refill, cachePkg::Finish};
  assign miss     = ((state == cachePkg::Lookup) && !hit) || stall;
  assign memReq   = state inside {cachePkg::WriteBack, cachePkg::Refill};
  assign memWrite = (state == cachePkg::WriteBack);

  // victim line address on write-back, request line otherwise
  assign memAddr = {memWrite ? selRead.tag : cpuReq.addr[31 -: cachePkg::TagBits],
                    cpuReq.addr[cachePkg::SetBits+cachePkg::WordBits+1:cachePkg::WordBits+2],
                    {(cachePkg::WordBits+2){1'b0}}};
  assign wdata   = selRead.line[{count, 5'd0} +: 32];

endmodule

/* rtl/cachePkg.sv */
package cachePkg;

  //////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////
  localparam int TagBits   = 18;
  localparam int SetBits   = 8;
  localparam int WordBits  = 4;   // word offset inside a line
  localparam int NumWays   = 4;
  localparam int LineWords = 16;
  localparam int NumSets   = 256;

  //////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////
  typedef logic [TagBits-1:0]        tagT;
  typedef logic [SetBits-1:0]        setT;
  typedef logic [WordBits-1:0]       wordIdxT;
  typedef logic [31:0]               wordT;
  typedef logic [3:0]                byteEnT;  // one bit per byte lane
  typedef logic [1:0]                ageT;
  typedef logic [1:0]                wayIdxT;
  typedef logic [NumWays-1:0]        wayMaskT;
  typedef logic [LineWords*32-1:0]   lineT;    // word 0 in the low bits

  // cpu request, held by the cpu until ok
  typedef struct packed {
    logic [31:0] addr;
    wordT        wdata;
    byteEnT      byteEn;
    logic        write;
  } cpuReqT;

  // what one way returns a cycle after it is addressed
  typedef struct packed {
    tagT  tag;
    logic valid;
    logic dirty;
    lineT line;
  } wayReadT;

  typedef enum logic [2:0] {
    Idle,
    Lookup,
    WriteBack,
    Refill,
    Finish
  } ctrlStateT;

endpackage

/* rtl/hitSelect.sv */
`timescale 1ns/1ps

module hitSelect (
  input  cachePkg::tagT                             reqTag,
  input  cachePkg::wayReadT [cachePkg::NumWays-1:0] ways,
  input  cachePkg::ageT [cachePkg::NumWays-1:0]     ages,
  output logic                                      hit,
  output cachePkg::wayMaskT                         hitWays,
  output cachePkg::wayIdxT                          selWay
);

  cachePkg::wayIdxT hitIdx;
  cachePkg::wayIdxT invIdx;
  cachePkg::wayIdxT oldIdx;
  logic             anyInv;

  always_comb begin
    for (int w = 0; w < cachePkg::NumWays; w++) begin
      hitWays[w] = ways[w].valid && (ways[w].tag == reqTag);
    end
  end

  assign hit = |hitWays;

  //////////////////////////////////////////////////
  // candidates, lowest way first
  //////////////////////////////////////////////////
  always_comb begin
    hitIdx = '0;
    invIdx = '0;
    anyInv = 1'b0;
    for (int w = cachePkg::NumWays - 1; w >= 0; w--) begin
      if (hitWays[w]) begin
        hitIdx = cachePkg::wayIdxT'(w);
      end
      if (!ways[w].valid) begin
        invIdx = cachePkg::wayIdxT'(w);
        anyInv = 1'b1;
      end
    end
  end

  // oldest way, strict compare keeps the lower way on a tie
  always_comb begin
    oldIdx = '0;
    for (int w = 1; w < cachePkg::NumWays; w++) begin
      if (ages[w] > ages[oldIdx]) begin
        oldIdx = cachePkg::wayIdxT'(w);
      end
    end
  end

  assign selWay = hit ? hitIdx : (anyInv ? invIdx : oldIdx);

endmodule

/* rtl/lruAges.sv */
`timescale 1ns/1ps

module lruAges (
  input  logic                                   clk,
  input  logic                                   addr_ok,
  input  cachePkg::setT                          setIdx,
  input  logic                                   touch,
  input  cachePkg::wayIdxT                       touchWay,
  output cachePkg::ageT [cachePkg::NumWays-1:0]  ages
);

  cachePkg::ageT [cachePkg::NumWays-1:0] ageMem [cachePkg::NumSets];
  cachePkg::ageT [cachePkg::NumWays-1:0] newAges;

  assign ages = ageMem[setIdx];  // combinational read

  //////////////////////////////////////////////////
  // age update on touch
  //////////////////////////////////////////////////
  // ways no older than the touched one get older,
  // the touched way becomes the youngest
  always_comb begin
    for (int w = 0; w < cachePkg::NumWays; w++) begin
      if (w == touchWay) begin
        newAges[w] = '0;
      end else if (ages[w] <= ages[touchWay] && ages[w] != 2'd3) begin
        newAges[w] = ages[w] + 2'd1;
      end else begin
        newAges[w] = ages[w];  // saturated or already older
      end
    end
  end

  always_ff @(posedge clk or posedge addr_ok) begin
    if (addr_ok) begin
      for (int s = 0; s < cachePkg::NumSets; s++) begin
        ageMem[s] <= '0;
      end
    end else if (touch) begin
      ageMem[setIdx] <= newAges;
    end
  end

endmodule

/* rtl/setCache.sv */
`timescale 1ns/1ps

module setCache (
  input  logic             clk,
  input  logic             addr_ok,
  input  logic             req,
  input  cachePkg::cpuReqT cpuReq,
  output cachePkg::wordT   rdata,
  output logic             ok,
  output logic             stall,
  output logic             miss,
  output logic             memReq,
  output logic             memWrite,
  output logic [31:0]      memAddr,
  output cachePkg::wordT   wdata,
  input  logic             dataOk,
  input  cachePkg::wordT   memRdata
);

  cachePkg::setT                             setIdx;
  cachePkg::tagT                             reqTag;
  cachePkg::wayReadT [cachePkg::NumWays-1:0] wayRd;
  cachePkg::wayReadT                         selRead;
  cachePkg::ageT [cachePkg::NumWays-1:0]     ages;
  logic                                      hit;
  cachePkg::wayMaskT                         hitWays;
  cachePkg::wayIdxT                          selWay;
  cachePkg::wayMaskT                         lineWe;
  cachePkg::wayMaskT                         tagWe;
  cachePkg::wayMaskT                         setValid;
  cachePkg::wayMaskT                         setDirty;
  cachePkg::wayMaskT                         clrDirty;
  cachePkg::byteEnT                          byteEn;
  cachePkg::wordIdxT                         wordIdx;
  cachePkg::wordT                            wrWord;
  logic                                      touch;

  assign setIdx  = cpuReq.addr[cachePkg::SetBits+cachePkg::WordBits+1:cachePkg::WordBits+2];
  assign reqTag  = cpuReq.addr[31 -: cachePkg::TagBits];
  assign selRead = wayRd[selWay];

  //////////////////////////////////////////////////
  // four ways
  //////////////////////////////////////////////////
  for (genvar w = 0; w < cachePkg::NumWays; w++) begin : gWay
    wayStore i_wayStore (
      .clk      (clk),
      .addr_ok  (addr_ok),
      .setIdx   (setIdx),
      .lineWe   (lineWe[w]),
      .wordIdx  (wordIdx),
      .byteEn   (byteEn),
      .wrWord   (wrWord),
      .tagWe    (tagWe[w]),
      .newTag   (reqTag),
      .setValid (setValid[w]),
      .setDirty (setDirty[w]),
      .clrDirty (clrDirty[w]),
      .rd       (wayRd[w])
    );
  end

  lruAges i_lruAges (
    .clk      (clk),
    .addr_ok  (addr_ok),
    .setIdx   (setIdx),
    .touch    (touch),
    .touchWay (selWay),
    .ages     (ages)
  );

  hitSelect i_hitSelect (
    .reqTag  (reqTag),
    .ways    (wayRd),
    .ages    (ages),
    .hit     (hit),
    .hitWays (hitWays),
    .selWay  (selWay)
  );

  cacheCtrl i_cacheCtrl (
    .clk      (clk),
    .addr_ok  (addr_ok),
    .req      (req),
    .cpuReq   (cpuReq),
    .rdata    (rdata),
    .ok       (ok),
    .stall    (stall),
    .miss     (miss),
    .hit      (hit),
    .hitWays  (hitWays),
    .selWay   (selWay),
    .selRead  (selRead),
    .lineWe   (lineWe),
    .byteEn   (byteEn),
    .wordIdx  (wordIdx),
    .wrWord   (wrWord),
    .tagWe    (tagWe),
    .setValid (setValid),
    .setDirty (setDirty),
    .clrDirty (clrDirty),
    .touch    (touch),
    .memReq   (memReq),
    .memWrite (memWrite),
    .memAddr  (memAddr),
    .wdata    (wdata),
    .dataOk   (dataOk),
    .memRdata (memRdata)
  );

endmodule

/* rtl/wayStore.sv */
`timescale 1ns/1ps

module wayStore (
  input  logic              clk,
  input  logic              addr_ok,
  input  cachePkg::setT     setIdx,
  input  logic              lineWe,
  input  cachePkg::wordIdxT wordIdx,
  input  cachePkg::byteEnT  byteEn,
  input  cachePkg::wordT    wrWord,
  input  logic              tagWe,
  input  cachePkg::tagT     newTag,
  input  logic              setValid,
  input  logic              setDirty,
  input  logic              clrDirty,
  output cachePkg::wayReadT rd
);

  cachePkg::tagT  tagMem  [cachePkg::NumSets];
  cachePkg::lineT dataMem [cachePkg::NumSets];

  logic [cachePkg::NumSets-1:0] validBits;
  logic [cachePkg::NumSets-1:0] dirtyBits;

  cachePkg::lineT curLine;
  cachePkg::lineT wrLine;
  logic           nextValid;
  logic           nextDirty;

  //////////////////////////////////////////////////
  // byte-masked word merge into the addressed line
  //////////////////////////////////////////////////
  always_comb begin
    curLine = dataMem[setIdx];
    wrLine  = curLine;
    for (int b = 0; b < $bits(cachePkg::byteEnT); b++) begin
      if (byteEn[b]) begin
        wrLine[{wordIdx, 5'd0} + b*8 +: 8] = wrWord[b*8 +: 8];
      end
    end
  end

  assign nextValid = setValid | validBits[setIdx];
  assign nextDirty = setDirty | (dirtyBits[setIdx] & ~clrDirty);  // set wins

  always_ff @(posedge clk or posedge addr_ok) begin
    if (addr_ok) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else begin
      validBits[setIdx] <= nextValid;
      dirtyBits[setIdx] <= nextDirty;
    end
  end

  // write-first read, so a word written this cycle is seen next cycle
  always_ff @(posedge clk) begin
    if (lineWe) begin
      dataMem[setIdx] <= wrLine;
    end
    if (tagWe) begin
      tagMem[setIdx] <= newTag;
    end
    rd.line  <= lineWe ? wrLine : curLine;
    rd.tag   <= tagWe ? newTag : tagMem[setIdx];
    rd.valid <= nextValid;
    rd.dirty <= nextDirty;
  end

endmodule

/* setCache.f */
rtl/cachePkg.sv
rtl/wayStore.sv
rtl/lruAges.sv
rtl/hitSelect.sv
rtl/cacheCtrl.sv
rtl/setCache.sv
bench/clockGen.sv
bench/memModel.sv
bench/setCacheTb.sv
